/* tb.f */
+incdir+logic
logic/mult_pkg.sv
logic/booth_digit_if.sv
logic/booth_encoder.sv
logic/pp_generator.sv
logic/csa_tree.sv
logic/prefix_adder.sv
logic/pipe_ctrl.sv
logic/mult_top.sv
sim/mult_sva.sv
sim/mult_tb.sv

/* Bender.yml */
package:
  name: booth_mult

sources:
  - include_dirs:
      - logic
    files:
      - logic/mult_pkg.sv
      - logic/booth_digit_if.sv
      - logic/booth_encoder.sv
      - logic/pp_generator.sv
      - logic/csa_tree.sv
      - logic/prefix_adder.sv
      - logic/pipe_ctrl.sv
      - logic/mult_top.sv
  - target: simulation
    files:
      - sim/mult_sva.sv
      - sim/mult_tb.sv

/* sim/mult_tb.sv */
`timescale 1ns/100ps

module mult_tb;

   import mult_pkg::*;

   localparam int max_cycles = 1000;
   localparam int n_stream   = 300;
   localparam int n_pattern  = 100;
   localparam int n_hold     = 20;

   // Corner operands and one pair per Booth digit value
   localparam operand_t dir_a [20] = '{8'd0, 8'd255, 8'd1, 8'd173, 8'd128, 8'd1, 8'd64,
      8'd16, 8'd200, 8'd200, 8'd200, 8'd200, 8'd200, 8'd77, 8'd77, 8'd77, 8'd255, 8'd3,
      8'd0, 8'd99};
   localparam operand_t dir_b [20] = '{8'd0, 8'd255, 8'd173, 8'd1, 8'd128, 8'd128, 8'd2,
      8'd32, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'h38, 8'hc0, 8'he0, 8'haa, 8'h55, 8'hff, 8'h92};

   logic     CLK;
   logic     rst_n;
   logic     in_valid;
   operand_t a;
   operand_t b;
   prod_t    product;
   logic     out_valid;

   int cycles       = 0;
   int issued       = 0;
   int results      = 0;
   int tests_failed = 0;
   int fails_before = 0;
   int other_errors = 0;

   mult_top dut0 (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .product   (product),
      .out_valid (out_valid)
   );

   always #50 CLK = ~CLK;

   always @(posedge CLK) begin
      cycles++;
      if (rst_n && in_valid) issued++;
      if (rst_n && out_valid) results++;
      if (cycles >= max_cycles) begin
         $display("Timeout: run stopped after %0d cycles", max_cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   function automatic int total_fails();
      return dut0.u_sva.fail_count + other_errors;
   endfunction

   task automatic drive(input logic v, input operand_t xa, input operand_t xb);
      @(posedge CLK);
      #10;
      in_valid = v;
      a        = xa;
      b        = xb;
   endtask

   // One pair, then idle until its result shows up
   task automatic send_gapped(input operand_t xa, input operand_t xb);
      int waited;
      drive(1'b1, xa, xb);
      drive(1'b0, xa, xb);
      waited = 0;
      while (!out_valid && waited < 8) begin
         @(posedge CLK);
         #10;
         waited++;
      end
      if (!out_valid) begin
         other_errors++;
         $display("No result appeared for a=0x%h b=0x%h", xa, xb);
      end
   endtask

   task automatic drain();
      drive(1'b0, a, b);
      repeat (3) @(posedge CLK);
   endtask

   task automatic report_test(input string name);
      int now_fails;
      now_fails = total_fails();
      if (now_fails == fails_before) begin
         $display("test %-9s ok", name);
      end else begin
         tests_failed++;
         $display("test %-9s %0d failures", name, now_fails - fails_before);
      end
      fails_before = now_fails;
   endtask

   initial begin
      CLK      = 1'b0;
      rst_n    = 1'b1;
      in_valid = 1'b0;
      a        = '0;
      b        = '0;
      void'($urandom(62));

      #1;
      rst_n = 1'b0;
      repeat (8) @(posedge CLK);
      #10;
      rst_n = 1'b1;
      repeat (3) @(posedge CLK);
      report_test("reset");

      for (int i = 0; i < 20; i++) begin
         send_gapped(dir_a[i], dir_b[i]);
      end
      report_test("directed");

      for (int i = 0; i < n_stream; i++) begin
         drive(1'b1, 8'($urandom), 8'($urandom));
      end
      drain();
      report_test("stream");

      for (int i = 0; i < n_pattern; i++) begin
         drive(1'($urandom), 8'($urandom), 8'($urandom));
      end
      drain();
      report_test("timing");

      // Operands keep moving with in_valid low
      for (int i = 0; i < n_hold; i++) begin
         drive(1'b0, 8'($urandom), 8'($urandom));
      end
      report_test("hold");

      if (results != issued) begin
         other_errors++;
         $display("Result count wrong: %0d pairs issued but %0d results seen", issued, results);
      end
      $display("tests 5, failing tests %0d, assertion failures %0d, other errors %0d",
               tests_failed, dut0.u_sva.fail_count, other_errors);
      if (total_fails() == 0 && tests_failed == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* sim/mult_sva.sv */
`timescale 1ns/100ps

module mult_sva (
   input logic               CLK,
   input logic               rst_n,
   input logic               in_valid,
   input mult_pkg::operand_t a,
   input mult_pkg::operand_t b,
   input mult_pkg::prod_t    product,
   input logic               out_valid
);

   import mult_pkg::*;

   int unsigned fail_count = 0;

   // Expected product and valid, two edges deep
   prod_t      exp_d1;
   prod_t      exp_d2;
   logic       vld_d1;
   logic       vld_d2;
   prod_t      prev_product;
   logic [1:0] settle;
   logic       seen_result;

   always @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         vld_d1      <= 1'b0;
         vld_d2      <= 1'b0;
         settle      <= 2'd0;
         seen_result <= 1'b0;
      end else begin
         vld_d1 <= in_valid;
         vld_d2 <= vld_d1;
         if (settle != 2'd2) begin
            settle <= settle + 2'd1;
         end
         if (out_valid) begin
            seen_result <= 1'b1;
         end
      end
   end

   always @(posedge CLK) begin
      exp_d1       <= prod_t'(a) * prod_t'(b);
      exp_d2       <= exp_d1;
      prev_product <= product;
   end

   // Reset and the first two edges after release
   a_reset_valid: assert property (@(posedge CLK) (!rst_n || settle != 2'd2) |-> !out_valid)
      else begin
         fail_count++;
         $error("** Error: out_valid expected 0x0 actual 0x%h", $sampled(out_valid));
      end

   a_reset_product: assert property (@(posedge CLK) (!rst_n || settle != 2'd2) |-> product == '0)
      else begin
         fail_count++;
         $error("** Error: product expected 0x0000 actual 0x%h", $sampled(product));
      end

   a_product: assert property (@(posedge CLK) disable iff (!rst_n)
                               in_valid |-> ##2 product == exp_d2)
      else begin
         fail_count++;
         $error("** Error: product expected 0x%h actual 0x%h",
                $sampled(exp_d2), $sampled(product));
      end

   a_valid_timing: assert property (@(posedge CLK) disable iff (!rst_n) out_valid == vld_d2)
      else begin
         fail_count++;
         $error("** Error: out_valid expected 0x%h actual 0x%h",
                $sampled(vld_d2), $sampled(out_valid));
      end

   // Product register only loads together with out_valid
   a_hold: assert property (@(posedge CLK) disable iff (!rst_n)
                            (seen_result && !out_valid) |-> product == prev_product)
      else begin
         fail_count++;
         $error("** Error: product expected 0x%h actual 0x%h while idle",
                $sampled(prev_product), $sampled(product));
      end

endmodule

bind mult_top mult_sva u_sva (
   .CLK       (CLK),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .a         (a),
   .b         (b),
   .product   (product),
   .out_valid (out_valid)
);

/* logic/mult_top.sv */
`timescale 1ns/100ps

module mult_top (
   input  logic               CLK,
   input  logic               rst_n,
   input  logic               in_valid,
   input  mult_pkg::operand_t a,
   input  mult_pkg::operand_t b,
   output mult_pkg::prod_t    product,
   output logic               out_valid
);

   import mult_pkg::*;

   pp_row_t    pp0;
   pp_row_t    pp1;
   pp_row_t    pp2;
   prod_t      corr;
   add_word_t  sum_row;
   add_word_t  carry_row;
   logic [1:0] low_bits;
   logic       stage1_en;
   logic       stage2_en;

   booth_digit_if dig ();

   booth_encoder u_booth_encoder (
      .b   (b),
      .dig (dig.enc)
   );

   pp_generator u_pp_generator (
      .a    (a),
      .dig  (dig.sel),
      .pp0  (pp0),
      .pp1  (pp1),
      .pp2  (pp2),
      .corr (corr)
   );

   // Stage 1 register at the tree output
   csa_tree u_csa_tree (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .stage1_en (stage1_en),
      .pp0       (pp0),
      .pp1       (pp1),
      .pp2       (pp2),
      .corr      (corr),
      .sum_row   (sum_row),
      .carry_row (carry_row),
      .low_bits  (low_bits)
   );

   prefix_adder u_prefix_adder (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .stage2_en (stage2_en),
      .sum_row   (sum_row),
      .carry_row (carry_row),
      .low_bits  (low_bits),
      .product   (product)
   );

   pipe_ctrl u_pipe_ctrl (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .stage1_en (stage1_en),
      .stage2_en (stage2_en),
      .out_valid (out_valid)
   );

endmodule

/* logic/pipe_ctrl.sv */
`timescale 1ns/100ps

module pipe_ctrl (
   input  logic CLK,
   input  logic rst_n,
   input  logic in_valid,
   output logic stage1_en,
   output logic stage2_en,
   output logic out_valid
);

   logic valid_d1;
   logic valid_d2;

   // Valid follows the data through both register stages
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         valid_d1 <= 1'b0;
         valid_d2 <= 1'b0;
      end else begin
         valid_d1 <= in_valid;
         valid_d2 <= valid_d1;
      end
   end

   // Tree rows load on the edge that samples the operands
   assign stage1_en = in_valid;

   assign stage2_en = valid_d1;
   assign out_valid = valid_d2;

endmodule

/* logic/prefix_adder.sv */
`timescale 1ns/100ps

`include "mult_defines.svh"

module prefix_adder (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                stage2_en,
   input  mult_pkg::add_word_t sum_row,
   input  mult_pkg::add_word_t carry_row,
   input  logic [1:0]          low_bits,
   output mult_pkg::prod_t     product
);

   import mult_pkg::*;

   add_word_t half_sum;
   add_word_t gen;
   add_word_t prop;
   add_word_t gen_nxt;
   add_word_t prop_nxt;
   add_word_t carry;
   add_word_t sum;

   assign half_sum = sum_row ^ carry_row;

   // Kogge-Stone style network, spans 1, 2, 4 and 8
   always_comb begin
      gen  = sum_row & carry_row;
      prop = half_sum;
      for (int l = 0; l < 4; l++) begin
         gen_nxt  = gen;
         prop_nxt = prop;
         for (int i = (1 << l); i < `MULT_ADD_WIDTH; i++) begin
            gen_nxt[i]  = gen[i] | (prop[i] & gen[i - (1 << l)]);
            prop_nxt[i] = prop[i] & prop[i - (1 << l)];
         end
         gen  = gen_nxt;
         prop = prop_nxt;
      end
   end

   // No carry in, gen[i] is the carry into bit i+1
   assign carry = {gen[`MULT_ADD_WIDTH-2:0], 1'b0};

   // Carry out of bit 13 lies above the product width
   assign sum = half_sum ^ carry;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         product <= '0;
      end else if (stage2_en) begin
         product <= {sum, low_bits};
      end
   end

endmodule

/* logic/csa_tree.sv */
`timescale 1ns/100ps

`include "mult_defines.svh"

module csa_tree (
   input  logic                CLK,
   input  logic                rst_n,
   input  logic                stage1_en,
   input  mult_pkg::pp_row_t   pp0,
   input  mult_pkg::pp_row_t   pp1,
   input  mult_pkg::pp_row_t   pp2,
   input  mult_pkg::prod_t     corr,
   output mult_pkg::add_word_t sum_row,
   output mult_pkg::add_word_t carry_row,
   output logic [1:0]          low_bits
);

   import mult_pkg::*;

   // Rows aligned to product weight
   prod_t row_b;
   prod_t row_c;
   prod_t row_lo;

   prod_t s1;
   prod_t c1;
   prod_t s2;
   prod_t c2;

   // Row of full adders, carries already shifted up one place.
   // Where an input is tied to zero the cell reduces to a half adder.
   function automatic void csa3(
      input  prod_t x,
      input  prod_t y,
      input  prod_t z,
      output prod_t s,
      output prod_t c
   );
      s = x ^ y ^ z;
      c = {(x[14:0] & y[14:0]) | (x[14:0] & z[14:0]) | (y[14:0] & z[14:0]), 1'b0};
   endfunction

   // Row 0 at bit 0 with the top of row 2 at bits 15..11
   assign row_b = {pp2[9:5], pp0};

   // Row 1 at bit 3
   assign row_c = {2'b00, pp1, 3'b000};

   // Low part of row 2 at bits 10..6
   assign row_lo = {5'b00000, pp2[4:0], 6'b000000};

   always_comb begin
      csa3(corr, row_b, row_c, s1, c1);
      csa3(s1, c1, row_lo, s2, c2);
   end

   // Bits 1..0 of s2 see no carry and are final
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         sum_row   <= '0;
         carry_row <= '0;
         low_bits  <= '0;
      end else if (stage1_en) begin
         sum_row   <= s2[15:2];
         carry_row <= c2[15:2];
         low_bits  <= s2[1:0];
      end
   end

endmodule

/* logic/pp_generator.sv */
`timescale 1ns/100ps

`include "mult_defines.svh"

module pp_generator (
   input  mult_pkg::operand_t a,
   booth_digit_if.sel         dig,
   output mult_pkg::pp_row_t  pp0,
   output mult_pkg::pp_row_t  pp1,
   output mult_pkg::pp_row_t  pp2,
   output mult_pkg::prod_t    corr
);

   // Multiples of a, all at the width of 3a
   logic [`MULT_TRIPLE_WIDTH-1:0] a_x1;
   logic [`MULT_TRIPLE_WIDTH-1:0] a_x2;
   logic [`MULT_TRIPLE_WIDTH-1:0] a_x3;
   logic [`MULT_TRIPLE_WIDTH-1:0] a_x4;

   // Selected and conditionally inverted multiple per group
   logic [`MULT_TRIPLE_WIDTH-1:0] sel_row [`MULT_GROUPS];

   assign a_x1 = {2'b00, a};
   assign a_x2 = {1'b0, a, 1'b0};
   assign a_x4 = {a, 2'b00};

   // Hard multiple, the only real adder ahead of the tree
   assign a_x3 = a_x1 + a_x2;

   for (genvar j = 0; j < `MULT_GROUPS; j++) begin : g_sel
      logic [`MULT_TRIPLE_WIDTH-1:0] mag;

      assign mag = ({`MULT_TRIPLE_WIDTH{dig.single[j]}} & a_x1) |
                   ({`MULT_TRIPLE_WIDTH{dig.double[j]}} & a_x2) |
                   ({`MULT_TRIPLE_WIDTH{dig.triple[j]}} & a_x3) |
                   ({`MULT_TRIPLE_WIDTH{dig.quad[j]}}   & a_x4);

      // One's complement here, the +1 rides in the correction vector
      assign sel_row[j] = mag ^ {`MULT_TRIPLE_WIDTH{dig.neg[j]}};
   end

   // Inverted sign on top replaces the sign-extension run
   assign pp0 = {~dig.neg[0], sel_row[0]};
   assign pp1 = {~dig.neg[1], sel_row[1]};

   // Top group is never negative
   assign pp2 = {1'b0, sel_row[2]};

   // Upper part is -(2^10 + 2^13) mod 2^16 for the two inverted signs
   assign corr = {6'b110111, 6'b000000, dig.neg[1], 2'b00, dig.neg[0]};

endmodule

/* logic/booth_encoder.sv */
`timescale 1ns/100ps

`include "mult_defines.svh"

module booth_encoder (
   input  mult_pkg::operand_t b,
   booth_digit_if.enc         dig
);

   // Multiplier with a zero below bit 0 and zero fill on top
   logic [3*`MULT_GROUPS:0] b_ext;

   assign b_ext = {{(3*`MULT_GROUPS-`MULT_WIDTH){1'b0}}, b, 1'b0};

   for (genvar j = 0; j < `MULT_GROUPS; j++) begin : g_group
      logic [3:0] win;
      logic       x01;
      logic       x12;
      logic       x23;

      // Overlapping window, digit = -4*w3 + 2*w2 + w1 + w0
      assign win = b_ext[3*j +: 4];

      assign x01 = win[0] ^ win[1];
      assign x12 = win[1] ^ win[2];
      assign x23 = win[2] ^ win[3];

      // Magnitude 1
      assign dig.single[j] = x01 & ~x23;
      // Magnitude 2
      assign dig.double[j] = x12 & ~x01;
      // Magnitude 3
      assign dig.triple[j] = x23 & x01;
      // Magnitude 4
      assign dig.quad[j]   = x23 & ~x01 & ~x12;

      assign dig.neg[j]    = win[3];
   end

endmodule

/* logic/booth_digit_if.sv */
`timescale 1ns/100ps

`include "mult_defines.svh"

// Booth digit controls, one bit per group
interface booth_digit_if;

   logic [`MULT_GROUPS-1:0] single;
   logic [`MULT_GROUPS-1:0] double;
   logic [`MULT_GROUPS-1:0] triple;
   logic [`MULT_GROUPS-1:0] quad;
   logic [`MULT_GROUPS-1:0] neg;

   modport enc (output single, output double, output triple, output quad, output neg);

   modport sel (input single, input double, input triple, input quad, input neg);

endinterface

/* logic/mult_pkg.sv */
`include "mult_defines.svh"

package mult_pkg;

   // Unsigned operand, multiplicand or multiplier
   typedef logic [`MULT_WIDTH-1:0] operand_t;

   // One Booth partial-product row
   typedef logic [`MULT_PP_WIDTH-1:0] pp_row_t;

   // Operand of the prefix adder
   typedef logic [`MULT_ADD_WIDTH-1:0] add_word_t;

   typedef logic [`MULT_PROD_WIDTH-1:0] prod_t;

endpackage

/* logic/mult_defines.svh */
`ifndef MULT_DEFINES_SVH
`define MULT_DEFINES_SVH

// Operand width of the multiplier
`define MULT_WIDTH 8

// Radix-8 Booth groups over the multiplier
`define MULT_GROUPS 3

// 3a needs two bits above the operand
`define MULT_TRIPLE_WIDTH 10

// Selected multiple plus the sign-extension bit
`define MULT_PP_WIDTH 11

// Final adder covers product bits 15 down to 2
`define MULT_ADD_WIDTH 14

`define MULT_PROD_WIDTH 16

`endif
